/* logic/rc5_axil_regs.sv */
// AXI4-Lite register block with key, data, control and status, engine start sequencing
`timescale 1ns/1ps

module rc5_axil_regs (
	input  logic                   i_clk,
	input  logic                   i_rst,
	// AXI4-Lite slave
	input  rc5_pkg::axil_addr_t    i_awaddr,
	input  logic                   i_awvalid,
	output logic                   o_awready,
	input  rc5_pkg::rc5_word_t     i_wdata,
	input  logic [3:0]             i_wstrb,
	input  logic                   i_wvalid,
	output logic                   o_wready,
	output rc5_pkg::axil_resp_t    o_bresp,
	output logic                   o_bvalid,
	input  logic                   i_bready,
	input  rc5_pkg::axil_addr_t    i_araddr,
	input  logic                   i_arvalid,
	output logic                   o_arready,
	output rc5_pkg::rc5_word_t     o_rdata,
	output rc5_pkg::axil_resp_t    o_rresp,
	output logic                   o_rvalid,
	input  logic                   i_rready,
	// Key schedule side
	output logic                   o_key_start,
	output rc5_pkg::rc5_user_key_t o_user_key,
	input  logic                   i_key_ready,
	// Cipher side
	output logic                   o_blk_start,
	output logic                   o_blk_decrypt,
	output rc5_pkg::rc5_block_t    o_blk_din,
	input  rc5_pkg::rc5_block_t    i_blk_dout,
	input  logic                   i_blk_valid
);
	import rc5_pkg::*;

	rc5_word_t [RC5_KEY_WORDS-1:0] r_key;
	rc5_word_t r_din_hi;
	rc5_word_t r_din_lo;
	rc5_word_t r_dout_hi;
	rc5_word_t r_dout_lo;
	logic      r_busy;
	logic      r_done;

	logic       r_bvalid;
	logic       r_rvalid;
	axil_resp_t r_bresp;
	axil_resp_t r_rresp;
	rc5_word_t  r_rdata;

	logic      s_wr_hs;
	logic      s_rd_hs;
	logic      s_wr_ok;
	logic      s_rd_ok;
	logic      s_wr_ctrl;
	logic      s_key_go;
	logic      s_blk_go;
	rc5_word_t s_rd_word;

	// Byte lanes not strobed keep their old value
	function automatic rc5_word_t merge_wstrb(input rc5_word_t old_w, input rc5_word_t new_w,
		input logic [3:0] strb);
		rc5_word_t res;
		for (int k = 0; k < 4; k++)
			res[8*k +: 8] = strb[k] ? new_w[8*k +: 8] : old_w[8*k +: 8];
		return res;
	endfunction

	// --------------------------------------------------
	// Handshakes
	// --------------------------------------------------
	// AW and W taken together, only with no B pending
	assign s_wr_hs   = i_awvalid && i_wvalid && !r_bvalid;
	assign o_awready = s_wr_hs;
	assign o_wready  = s_wr_hs;
	// One read in flight
	assign o_arready = !r_rvalid;
	assign s_rd_hs   = i_arvalid && !r_rvalid;

	// Write decode
	always_comb begin
		case (i_awaddr)
			REG_CTRL, REG_STATUS, REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3,
			REG_DIN_HI, REG_DIN_LO, REG_DOUT_HI, REG_DOUT_LO: s_wr_ok = 1'b1;
			default: s_wr_ok = 1'b0;
		endcase
	end

	// Read mux, unmapped reads return zero
	always_comb begin
		s_rd_ok   = 1'b1;
		s_rd_word = '0;
		case (i_araddr)
			REG_CTRL:    s_rd_word = '0;
			REG_STATUS:  s_rd_word = {29'd0, r_done, r_busy, i_key_ready};
			REG_KEY0:    s_rd_word = r_key[0];
			REG_KEY1:    s_rd_word = r_key[1];
			REG_KEY2:    s_rd_word = r_key[2];
			REG_KEY3:    s_rd_word = r_key[3];
			REG_DIN_HI:  s_rd_word = r_din_hi;
			REG_DIN_LO:  s_rd_word = r_din_lo;
			REG_DOUT_HI: s_rd_word = r_dout_hi;
			REG_DOUT_LO: s_rd_word = r_dout_lo;
			default:     s_rd_ok   = 1'b0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_bvalid <= 1'b0;
			r_bresp  <= RESP_OKAY;
			r_rvalid <= 1'b0;
			r_rresp  <= RESP_OKAY;
		end else begin
			if (s_wr_hs) begin
				r_bvalid <= 1'b1;
				r_bresp  <= s_wr_ok ? RESP_OKAY : RESP_SLVERR;
			end else if (i_bready) begin
				r_bvalid <= 1'b0;
			end
			if (s_rd_hs) begin
				r_rvalid <= 1'b1;
				r_rresp  <= s_rd_ok ? RESP_OKAY : RESP_SLVERR;
			end else if (i_rready) begin
				r_rvalid <= 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// Engine control
	// --------------------------------------------------
	assign s_wr_ctrl = s_wr_hs && (i_awaddr == REG_CTRL) && i_wstrb[0];
	// Key start refused during a block
	assign s_key_go  = s_wr_ctrl && i_wdata[CTRL_KEY_START] && !r_busy;
	// Block needs a finished table, a combined write prefers the key start
	assign s_blk_go  = s_wr_ctrl && i_wdata[CTRL_BLK_START] && !i_wdata[CTRL_KEY_START] &&
		!r_busy && i_key_ready;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_key_start <= 1'b0;
			o_blk_start <= 1'b0;
			r_busy      <= 1'b0;
			r_done      <= 1'b0;
		end else begin
			o_key_start <= s_key_go;
			o_blk_start <= s_blk_go;
			if (s_blk_go) begin
				r_busy <= 1'b1;
				r_done <= 1'b0;
			end else if (i_blk_valid) begin
				r_busy <= 1'b0;
				r_done <= 1'b1;
			end
		end
	end

	// Data registers and read data
	always_ff @(posedge i_clk) begin
		if (s_blk_go)
			o_blk_decrypt <= i_wdata[CTRL_DECRYPT];
		if (s_wr_hs) begin
			case (i_awaddr)
				REG_KEY0:   r_key[0] <= merge_wstrb(r_key[0], i_wdata, i_wstrb);
				REG_KEY1:   r_key[1] <= merge_wstrb(r_key[1], i_wdata, i_wstrb);
				REG_KEY2:   r_key[2] <= merge_wstrb(r_key[2], i_wdata, i_wstrb);
				REG_KEY3:   r_key[3] <= merge_wstrb(r_key[3], i_wdata, i_wstrb);
				REG_DIN_HI: r_din_hi <= merge_wstrb(r_din_hi, i_wdata, i_wstrb);
				REG_DIN_LO: r_din_lo <= merge_wstrb(r_din_lo, i_wdata, i_wstrb);
				default: ;
			endcase
		end
		// Result capture on the one-cycle valid
		if (i_blk_valid) begin
			r_dout_hi <= i_blk_dout[63:32];
			r_dout_lo <= i_blk_dout[31:0];
		end
		if (s_rd_hs)
			r_rdata <= s_rd_word;
	end

	assign o_bvalid   = r_bvalid;
	assign o_bresp    = r_bresp;
	assign o_rvalid   = r_rvalid;
	assign o_rresp    = r_rresp;
	assign o_rdata    = r_rdata;
	// KEY0 is the low word
	assign o_user_key = r_key;
	assign o_blk_din  = {r_din_hi, r_din_lo};

endmodule

/* logic/rc5_block_cipher.sv */
// RC5 round-iterative encrypt and decrypt datapath, one round per clock
`timescale 1ns/1ps

module rc5_block_cipher (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_start,
	input  logic                    i_decrypt,
	input  rc5_pkg::rc5_block_t     i_din,
	input  rc5_pkg::rc5_key_table_t i_table,
	output rc5_pkg::rc5_block_t     o_dout,
	output logic                    o_valid
);
	import rc5_pkg::*;

	localparam logic [3:0] LAST_CNT = 4'(RC5_ROUNDS - 1);
	// Round keys left after the first round
	localparam int RKEY_WORDS = RC5_TABLE_WORDS - 4;

	// Zero when idle, else the number of rounds already done
	logic [3:0] r_cnt;
	logic       r_enc;
	rc5_word_t  r_a;
	rc5_word_t  r_b;
	rc5_word_t [RKEY_WORDS-1:0] r_rkey;

	logic      s_enc;
	rc5_word_t s_a;
	rc5_word_t s_b;
	rc5_word_t s_ka;
	rc5_word_t s_kb;
	rc5_word_t s_a_nx;
	rc5_word_t s_b_nx;

	// --------------------------------------------------
	// Sequencing
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_cnt <= '0;
			r_enc <= 1'b1;
		end else if (i_start) begin
			r_cnt <= 4'd1;
			r_enc <= !i_decrypt;
		end else if (r_cnt == LAST_CNT) begin
			r_cnt <= '0;
		end else if (r_cnt != 4'd0) begin
			r_cnt <= r_cnt + 4'd1;
		end
	end

	// Key pipe, next pair always at the low end for encrypt and top end for decrypt
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			if (i_decrypt)
				r_rkey <= i_table[RC5_TABLE_WORDS-3:2];
			else
				r_rkey <= i_table[RC5_TABLE_WORDS-1:4];
		end else if (r_cnt != 4'd0) begin
			if (r_enc)
				r_rkey <= {64'd0, r_rkey[RKEY_WORDS-1:2]};
			else
				r_rkey <= {r_rkey[RKEY_WORDS-3:0], 64'd0};
		end
	end

	// Round state
	always_ff @(posedge i_clk) begin
		r_a <= s_a_nx;
		r_b <= s_b_nx;
	end

	// --------------------------------------------------
	// Round logic
	// --------------------------------------------------
	always_comb begin
		// Mode straight from the port on the start cycle
		s_enc = i_start ? !i_decrypt : r_enc;
		if (i_start) begin
			s_a = rc5_byteswap(i_din[63:32]);
			s_b = rc5_byteswap(i_din[31:0]);
			// Pre-whitening folded into round 1
			if (s_enc) begin
				s_a = s_a + i_table[0];
				s_b = s_b + i_table[1];
			end
			s_ka = s_enc ? i_table[2] : i_table[RC5_TABLE_WORDS-2];
			s_kb = s_enc ? i_table[3] : i_table[RC5_TABLE_WORDS-1];
		end else begin
			s_a  = r_a;
			s_b  = r_b;
			s_ka = s_enc ? r_rkey[0] : r_rkey[RKEY_WORDS-2];
			s_kb = s_enc ? r_rkey[1] : r_rkey[RKEY_WORDS-1];
		end

		if (s_enc) begin
			s_a_nx = rc5_rotl(s_a ^ s_b, s_b) + s_ka;
			s_b_nx = rc5_rotl(s_b ^ s_a_nx, s_a_nx) + s_kb;
		end else begin
			// B first, then A with the new B
			s_b_nx = rc5_rotr(s_b - s_kb, s_a) ^ s_a;
			s_a_nx = rc5_rotr(s_a - s_ka, s_b_nx) ^ s_b_nx;
		end
	end

	// Post-whitening of decrypt in the last round, back to byte order
	assign o_dout = s_enc ?
		{rc5_byteswap(s_a_nx), rc5_byteswap(s_b_nx)} :
		{rc5_byteswap(s_a_nx - i_table[0]), rc5_byteswap(s_b_nx - i_table[1])};

	assign o_valid = (r_cnt == LAST_CNT);

endmodule

/* logic/rc5_crypto_top.sv */
// RC5 crypto top level with register block, key schedule and cipher
`timescale 1ns/1ps

module rc5_crypto_top (
	input  logic                i_clk,
	input  logic                i_rst,
	// AXI4-Lite slave
	input  rc5_pkg::axil_addr_t i_awaddr,
	input  logic                i_awvalid,
	output logic                o_awready,
	input  rc5_pkg::rc5_word_t  i_wdata,
	input  logic [3:0]          i_wstrb,
	input  logic                i_wvalid,
	output logic                o_wready,
	output rc5_pkg::axil_resp_t o_bresp,
	output logic                o_bvalid,
	input  logic                i_bready,
	input  rc5_pkg::axil_addr_t i_araddr,
	input  logic                i_arvalid,
	output logic                o_arready,
	output rc5_pkg::rc5_word_t  o_rdata,
	output rc5_pkg::axil_resp_t o_rresp,
	output logic                o_rvalid,
	input  logic                i_rready
);
	import rc5_pkg::*;

	// Key schedule link
	logic           key_start;
	logic           key_ready;
	rc5_user_key_t  user_key;
	rc5_key_table_t key_table;

	// Cipher link
	logic       blk_start;
	logic       blk_decrypt;
	logic       blk_valid;
	rc5_block_t blk_din;
	rc5_block_t blk_dout;

	rc5_axil_regs u_regs (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_awaddr      (i_awaddr),
		.i_awvalid     (i_awvalid),
		.o_awready     (o_awready),
		.i_wdata       (i_wdata),
		.i_wstrb       (i_wstrb),
		.i_wvalid      (i_wvalid),
		.o_wready      (o_wready),
		.o_bresp       (o_bresp),
		.o_bvalid      (o_bvalid),
		.i_bready      (i_bready),
		.i_araddr      (i_araddr),
		.i_arvalid     (i_arvalid),
		.o_arready     (o_arready),
		.o_rdata       (o_rdata),
		.o_rresp       (o_rresp),
		.o_rvalid      (o_rvalid),
		.i_rready      (i_rready),
		.o_key_start   (key_start),
		.o_user_key    (user_key),
		.i_key_ready   (key_ready),
		.o_blk_start   (blk_start),
		.o_blk_decrypt (blk_decrypt),
		.o_blk_din     (blk_din),
		.i_blk_dout    (blk_dout),
		.i_blk_valid   (blk_valid)
	);

	rc5_key_schedule u_keysched (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (key_start),
		.i_user_key (user_key),
		.o_ready    (key_ready),
		.o_table    (key_table)
	);

	rc5_block_cipher u_cipher (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_start   (blk_start),
		.i_decrypt (blk_decrypt),
		.i_din     (blk_din),
		.i_table   (key_table),
		.o_dout    (blk_dout),
		.o_valid   (blk_valid)
	);

endmodule

/* logic/rc5_key_schedule.sv */
// RC5 key expansion FSM, 128-bit user key into the 26-word table
`timescale 1ns/1ps

module rc5_key_schedule (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_start,
	input  rc5_pkg::rc5_user_key_t  i_user_key,
	output logic                    o_ready,
	output rc5_pkg::rc5_key_table_t o_table
);
	import rc5_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_INIT,
		ST_MIX,
		ST_DONE
	} ks_state_t;

	localparam logic [4:0] LAST_IDX  = 5'(RC5_TABLE_WORDS - 1);
	localparam logic [6:0] LAST_STEP = 7'(RC5_MIX_STEPS - 1);

	ks_state_t r_state;
	// Table index i, key index j, mixing step count
	logic [4:0] r_idx;
	logic [1:0] r_jdx;
	logic [6:0] r_step;
	logic       s_accept;

	// Running P + i*Q during fill
	rc5_word_t r_sum;
	// Mixing accumulators
	rc5_word_t r_a;
	rc5_word_t r_b;
	rc5_word_t [RC5_KEY_WORDS-1:0] r_l;
	rc5_key_table_t r_table;
	rc5_word_t s_a_nx;
	rc5_word_t s_b_nx;

	// Restart allowed only between expansions
	assign s_accept = i_start && (r_state == ST_IDLE || r_state == ST_DONE);

	// --------------------------------------------------
	// One mixing step
	// --------------------------------------------------
	// A = S[i] = (S[i] + A + B) <<< 3
	assign s_a_nx = rc5_rotl(r_table[r_idx] + r_a + r_b, 32'd3);
	// B = L[j] = (L[j] + A + B) <<< (A + B)
	assign s_b_nx = rc5_rotl(r_l[r_jdx] + s_a_nx + r_b, s_a_nx + r_b);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= ST_IDLE;
			r_idx   <= '0;
			r_jdx   <= '0;
			r_step  <= '0;
		end else begin
			case (r_state)
				ST_IDLE, ST_DONE: begin
					if (i_start) begin
						r_state <= ST_INIT;
						r_idx   <= '0;
					end
				end
				ST_INIT: begin
					if (r_idx == LAST_IDX) begin
						r_state <= ST_MIX;
						r_idx   <= '0;
						r_jdx   <= '0;
						r_step  <= '0;
					end else begin
						r_idx <= r_idx + 5'd1;
					end
				end
				ST_MIX: begin
					// i wraps at 26, j wraps at 4 by width
					r_idx  <= (r_idx == LAST_IDX) ? 5'd0 : r_idx + 5'd1;
					r_jdx  <= r_jdx + 2'd1;
					r_step <= r_step + 7'd1;
					if (r_step == LAST_STEP)
						r_state <= ST_DONE;
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	// Table and working words
	always_ff @(posedge i_clk) begin
		if (s_accept) begin
			r_sum <= RC5_P32;
			// KEY0 lands in L[0]
			r_l   <= i_user_key;
			r_a   <= '0;
			r_b   <= '0;
		end else if (r_state == ST_INIT) begin
			r_table[r_idx] <= r_sum;
			r_sum          <= r_sum + RC5_Q32;
		end else if (r_state == ST_MIX) begin
			r_table[r_idx] <= s_a_nx;
			r_l[r_jdx]     <= s_b_nx;
			r_a            <= s_a_nx;
			r_b            <= s_b_nx;
		end
	end

	assign o_ready = (r_state == ST_DONE);
	assign o_table = r_table;

endmodule

/* logic/rc5_pkg.sv */
// RC5 constants, word and key types, register offsets, rotate and byte swap functions
package rc5_pkg;

	// Basic vector types
	typedef logic [31:0]  rc5_word_t;
	typedef logic [63:0]  rc5_block_t;
	typedef logic [127:0] rc5_user_key_t;
	typedef logic [7:0]   axil_addr_t;
	typedef logic [1:0]   axil_resp_t;

	// --------------------------------------------------
	// Algorithm constants
	// --------------------------------------------------
	localparam int RC5_ROUNDS      = 12;
	localparam int RC5_TABLE_WORDS = 2 * RC5_ROUNDS + 2;
	localparam int RC5_KEY_WORDS   = 4;
	// Three passes over the larger of table and key
	localparam int RC5_MIX_STEPS   = 3 * RC5_TABLE_WORDS;
	localparam rc5_word_t RC5_P32  = 32'hB7E1_5163;
	localparam rc5_word_t RC5_Q32  = 32'h9E37_79B9;

	// Expanded table, S[i] sits at index i
	typedef rc5_word_t [RC5_TABLE_WORDS-1:0] rc5_key_table_t;

	// --------------------------------------------------
	// Register map and bus responses
	// --------------------------------------------------
	localparam axil_addr_t REG_CTRL    = 8'h00;
	localparam axil_addr_t REG_STATUS  = 8'h04;
	localparam axil_addr_t REG_KEY0    = 8'h10;
	localparam axil_addr_t REG_KEY1    = 8'h14;
	localparam axil_addr_t REG_KEY2    = 8'h18;
	localparam axil_addr_t REG_KEY3    = 8'h1C;
	localparam axil_addr_t REG_DIN_HI  = 8'h20;
	localparam axil_addr_t REG_DIN_LO  = 8'h24;
	localparam axil_addr_t REG_DOUT_HI = 8'h28;
	localparam axil_addr_t REG_DOUT_LO = 8'h2C;

	localparam axil_resp_t RESP_OKAY   = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	// CTRL bit positions
	localparam int CTRL_BLK_START = 0;
	localparam int CTRL_DECRYPT   = 1;
	localparam int CTRL_KEY_START = 2;

	// --------------------------------------------------
	// Word helpers
	// --------------------------------------------------
	// Rotate left by the low five bits of amt
	function automatic rc5_word_t rc5_rotl(input rc5_word_t w, input rc5_word_t amt);
		logic [63:0] dbl;
		dbl = {w, w} << amt[4:0];
		return dbl[63:32];
	endfunction

	function automatic rc5_word_t rc5_rotr(input rc5_word_t w, input rc5_word_t amt);
		logic [63:0] dbl;
		dbl = {w, w} >> amt[4:0];
		return dbl[31:0];
	endfunction

	// Byte stream order to little-endian word and back
	function automatic rc5_word_t rc5_byteswap(input rc5_word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

/* sim.f */
+incdir+testbench
logic/rc5_pkg.sv
logic/rc5_key_schedule.sv
logic/rc5_block_cipher.sv
logic/rc5_axil_regs.sv
logic/rc5_crypto_top.sv
testbench/rc5_tb.sv

/* testbench/rc5_tb_tasks.svh */
// AXI4-Lite write and read tasks, typed compare tasks for block, word and response

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_block(input string name, input rc5_block_t exp_val,
	input rc5_block_t act_val);
	if (act_val !== exp_val) begin
		value_errs++;
		$display("ERR %s expected %h actual %h", name, exp_val, act_val);
	end
endtask

task automatic check_word(input string name, input rc5_word_t exp_val,
	input rc5_word_t act_val);
	if (act_val !== exp_val) begin
		value_errs++;
		$display("ERR %s expected %h actual %h", name, exp_val, act_val);
	end
endtask

task automatic check_resp(input string name, input axil_resp_t exp_val,
	input axil_resp_t act_val);
	if (act_val !== exp_val) begin
		value_errs++;
		$display("ERR %s expected %b actual %b", name, exp_val, act_val);
	end
endtask

// --------------------------------------------------
// Bus transfers
// --------------------------------------------------
// AW and W offered together, B taken after a random delay
task automatic axil_write(input axil_addr_t addr, input rc5_word_t data,
	output axil_resp_t resp);
	int delay;
	awaddr  <= addr;
	wdata   <= data;
	wstrb   <= 4'hF;
	awvalid <= 1'b1;
	wvalid  <= 1'b1;
	do
		@(posedge i_clk);
	while (!(awready && wready));
	awvalid <= 1'b0;
	wvalid  <= 1'b0;
	delay = $urandom_range(3, 0);
	repeat (delay) @(posedge i_clk);
	bready <= 1'b1;
	do
		@(posedge i_clk);
	while (!bvalid);
	resp = bresp;
	bready <= 1'b0;
	// Exactly one response per write
	@(posedge i_clk);
	if (bvalid) begin
		other_errs++;
		$display("Write response for address 0x%h was repeated", addr);
	end
endtask

// AR then R with a random delay before rready
task automatic axil_read(input axil_addr_t addr, output rc5_word_t data,
	output axil_resp_t resp);
	int delay;
	araddr  <= addr;
	arvalid <= 1'b1;
	do
		@(posedge i_clk);
	while (!arready);
	arvalid <= 1'b0;
	delay = $urandom_range(3, 0);
	repeat (delay) @(posedge i_clk);
	rready <= 1'b1;
	do
		@(posedge i_clk);
	while (!rvalid);
	data = rdata;
	resp = rresp;
	rready <= 1'b0;
	@(posedge i_clk);
	if (rvalid) begin
		other_errs++;
		$display("Read response for address 0x%h was repeated", addr);
	end
endtask

/* testbench/rc5_tb.sv */
// RC5 testbench top with clock, reset, watchdog, test vector loop and closing report
`timescale 1ns/1ps

module rc5_tb;
	import rc5_pkg::*;

	localparam int POLL_LIMIT = 100;

	logic       i_clk;
	logic       i_rst;
	// Bus signals toward the DUT
	axil_addr_t awaddr;
	logic       awvalid;
	logic       awready;
	rc5_word_t  wdata;
	logic [3:0] wstrb;
	logic       wvalid;
	logic       wready;
	axil_resp_t bresp;
	logic       bvalid;
	logic       bready;
	axil_addr_t araddr;
	logic       arvalid;
	logic       arready;
	rc5_word_t  rdata;
	axil_resp_t rresp;
	logic       rvalid;
	logic       rready;

	int value_errs;
	int other_errs;
	bit vectors_loaded;

	// Vector columns
	bit            vec_dec [$];
	rc5_user_key_t vec_key [$];
	rc5_block_t    vec_din [$];
	rc5_block_t    vec_exp [$];

	axil_addr_t unmapped_addrs [3] = '{8'h08, 8'h30, 8'hFC};

	`include "rc5_tb_tasks.svh"

	rc5_crypto_top i_dut (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_awaddr  (awaddr),
		.i_awvalid (awvalid),
		.o_awready (awready),
		.i_wdata   (wdata),
		.i_wstrb   (wstrb),
		.i_wvalid  (wvalid),
		.o_wready  (wready),
		.o_bresp   (bresp),
		.o_bvalid  (bvalid),
		.i_bready  (bready),
		.i_araddr  (araddr),
		.i_arvalid (arvalid),
		.o_arready (arready),
		.o_rdata   (rdata),
		.o_rresp   (rresp),
		.o_rvalid  (rvalid),
		.i_rready  (rready)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	// Key byte 0 is leftmost in the file
	// KEY0 takes bytes 0..3 little-endian
	function automatic rc5_word_t user_key_word(input rc5_user_key_t k, input int w);
		rc5_word_t res;
		for (int b = 0; b < 4; b++)
			res[8*b +: 8] = k[127 - 8*(4*w + b) -: 8];
		return res;
	endfunction

	// Lines start with E or D
	// A hash starts a comment line
	task automatic load_vectors();
		int            fd;
		int            c;
		int            n;
		rc5_user_key_t key;
		rc5_block_t    din;
		rc5_block_t    exp_blk;
		logic [8*200-1:0] line;
		fd = $fopen("testbench/rc5_testdata.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("Could not open the test vector file");
			return;
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				n = $fgets(line, fd);
			end else if (c == "E" || c == "D") begin
				n = $fscanf(fd, " %h %h %h", key, din, exp_blk);
				if (n == 3) begin
					vec_dec.push_back(c == "D");
					vec_key.push_back(key);
					vec_din.push_back(din);
					vec_exp.push_back(exp_blk);
				end else begin
					other_errs++;
					$display("A test vector line could not be parsed");
				end
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
		if (vec_din.size() == 0) begin
			other_errs++;
			$display("No test vectors were read");
		end
	endtask

	// Read STATUS until the bit is set or the poll limit runs out
	task automatic poll_status(input int bit_idx, input string what);
		rc5_word_t  st;
		axil_resp_t resp;
		int         tries;
		st    = '0;
		tries = 0;
		while (!st[bit_idx] && tries < POLL_LIMIT) begin
			axil_read(REG_STATUS, st, resp);
			tries++;
		end
		if (!st[bit_idx]) begin
			other_errs++;
			$display("%s: STATUS bit %0d never came up", what, bit_idx);
		end
	endtask

	// Start, check done cleared, wait for done, check the result
	task automatic run_block(input int v, input string tag);
		rc5_word_t  hi;
		rc5_word_t  lo;
		rc5_word_t  st;
		axil_resp_t resp;
		axil_write(REG_CTRL, {30'd0, vec_dec[v], 1'b1}, resp);
		axil_read(REG_STATUS, st, resp);
		check_word({tag, " status while busy"}, 32'h3, st);
		poll_status(2, {tag, " block done"});
		axil_read(REG_STATUS, st, resp);
		check_word({tag, " status after result"}, 32'h5, st);
		axil_read(REG_DOUT_HI, hi, resp);
		axil_read(REG_DOUT_LO, lo, resp);
		check_block({tag, " dout"}, vec_exp[v], {hi, lo});
	endtask

	task automatic run_vector(input int v);
		rc5_word_t  rd;
		axil_resp_t resp;
		string      tag;
		tag = $sformatf("vector %0d", v);
		for (int w = 0; w < RC5_KEY_WORDS; w++) begin
			axil_write(REG_KEY0 + 8'(4*w), user_key_word(vec_key[v], w), resp);
			check_resp({tag, " key write resp"}, RESP_OKAY, resp);
		end
		for (int w = 0; w < RC5_KEY_WORDS; w++) begin
			axil_read(REG_KEY0 + 8'(4*w), rd, resp);
			check_resp({tag, " key read resp"}, RESP_OKAY, resp);
			check_word({tag, " key readback"}, user_key_word(vec_key[v], w), rd);
		end
		axil_write(REG_CTRL, 32'h4, resp);
		poll_status(0, {tag, " key ready"});
		axil_write(REG_DIN_HI, vec_din[v][63:32], resp);
		axil_write(REG_DIN_LO, vec_din[v][31:0], resp);
		axil_read(REG_DIN_HI, rd, resp);
		check_word({tag, " din hi readback"}, vec_din[v][63:32], rd);
		axil_read(REG_DIN_LO, rd, resp);
		check_word({tag, " din lo readback"}, vec_din[v][31:0], rd);
		run_block(v, tag);
		// Second start on the same block
		if (v == 0)
			run_block(v, {tag, " restart"});
	endtask

	// --------------------------------------------------
	// Watchdog
	// --------------------------------------------------
	initial begin
		int limit;
		wait (vectors_loaded);
		limit = vec_din.size() * 400 + 2000;
		repeat (limit) @(posedge i_clk);
		$display("Timeout after %0d cycles, the tests did not finish", limit);
		$display("Something failed");
		$finish;
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int         seed_ret;
		rc5_word_t  rd;
		axil_resp_t resp;
		i_rst   = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		value_errs = 0;
		other_errs = 0;
		seed_ret = $urandom(32'h4b0e_3a55);
		load_vectors();
		vectors_loaded = 1'b1;
		repeat (5) @(posedge i_clk);
		i_rst <= 1'b0;
		@(posedge i_clk);

		// No key yet, so a block start is ignored
		axil_read(REG_STATUS, rd, resp);
		check_word("status after reset", 32'h0, rd);
		axil_write(REG_CTRL, 32'h1, resp);
		repeat (20) @(posedge i_clk);
		axil_read(REG_STATUS, rd, resp);
		check_word("status after early start", 32'h0, rd);

		// Unmapped offsets
		foreach (unmapped_addrs[k]) begin
			axil_write(unmapped_addrs[k], 32'hDEAD_BEEF, resp);
			check_resp($sformatf("unmapped write 0x%h", unmapped_addrs[k]),
				RESP_SLVERR, resp);
			axil_read(unmapped_addrs[k], rd, resp);
			check_resp($sformatf("unmapped read 0x%h", unmapped_addrs[k]),
				RESP_SLVERR, resp);
			check_word($sformatf("unmapped data 0x%h", unmapped_addrs[k]), 32'h0, rd);
		end

		foreach (vec_din[v])
			run_vector(v);

		$display("Error count: %0d value mismatches, %0d other failures",
			value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* testbench/rc5_testdata.txt */
# mode (E encrypt, D decrypt), user key bytes 0..15, input block bytes 0..7, expected block
# all blocks in byte stream order, published RC5-32/12/16 answers and their inverses
E 00000000000000000000000000000000 0000000000000000 21A5DBEE154B8F6D
D 00000000000000000000000000000000 21A5DBEE154B8F6D 0000000000000000
E 915F4619BE41B2516355A50110A9CE91 21A5DBEE154B8F6D F7C013AC5B2B8952
D 915F4619BE41B2516355A50110A9CE91 F7C013AC5B2B8952 21A5DBEE154B8F6D
# same input block as above under a new key
E 783348E75AEB0F2FD7B169BB8DC16787 F7C013AC5B2B8952 2F42B3B70369FC92
D 783348E75AEB0F2FD7B169BB8DC16787 2F42B3B70369FC92 F7C013AC5B2B8952
E DC49DB1375A5584F6485B413B5F12BAF 2F42B3B70369FC92 65C178B284D197CC
D DC49DB1375A5584F6485B413B5F12BAF 65C178B284D197CC 2F42B3B70369FC92
E 5269F149D41BA0152497574D7F153125 65C178B284D197CC EB44E415DA319824
D 5269F149D41BA0152497574D7F153125 EB44E415DA319824 65C178B284D197CC
